// File: Makefile
TOP = convEngineTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f convEngine.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: convEngine.f
+incdir+hdl
hdl/convEnginePkg.sv
hdl/convDecode.sv
hdl/convExecute.sv
hdl/convResult.sv
hdl/convEngine.sv
verification/convChecker.sv
verification/convEngineTb.sv

// File: hdl/convDecode.sv
`include "convEngine_params.svh"

module convDecode (
    input  logic                     clk,
    input  logic                     convRst,
    input  convEnginePkg::layerCmd_t cmd,
    input  logic                     passDone,
    output logic                     startPass,
    output convEnginePkg::layerCfg_t cfg
);
    import convEnginePkg::*;

    logic busy;
    logic isConv;
    logic accept;

    // only conv opcodes start a pass, OP_IDLE falls through
    assign isConv = (cmd.op == OP_CONV_A2B) || (cmd.op == OP_CONV_B2A);
    assign accept = cmd.valid && isConv && !busy;   // dropped while a pass runs

    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            busy      <= 1'b0;
            startPass <= 1'b0;
        end else begin
            startPass <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (passDone) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // bank selection, held until the next accepted command
    always_ff @(posedge clk) begin
        if (accept) begin
            case (cmd.op)
                OP_CONV_B2A: begin
                    cfg.inBase  <= `LAYER_ADDR_WIDTH'(`BANK_B_BASE);
                    cfg.outBase <= `LAYER_ADDR_WIDTH'(`BANK_A_BASE);
                end
                default: begin
                    cfg.inBase  <= `LAYER_ADDR_WIDTH'(`BANK_A_BASE);
                    cfg.outBase <= `LAYER_ADDR_WIDTH'(`BANK_B_BASE);
                end
            endcase
        end
    end

endmodule

// File: hdl/convEngine.sv
`include "convEngine_params.svh"

module convEngine (
    input  logic                            clk,
    input  logic                            convRst,
    input  convEnginePkg::layerCmd_t        cmd,
    output logic [`LAYER_ADDR_WIDTH-1:0]    fmReadAddr,
    input  logic [`DATA_WIDTH-1:0]          fmReadData,
    output logic [`WEIGHT_ADDR_WIDTH-1:0]   weightReadAddr,
    input  logic [`WEIGHT_ROW_WIDTH-1:0]    weightReadData,   // three packed columns
    output logic [`KIDX_WIDTH-1:0]          biasReadAddr,
    input  logic [`DATA_WIDTH-1:0]          biasReadData,
    output convEnginePkg::layerWrite_t      layerWr,
    output logic                            convStatus
);
    import convEnginePkg::*;

    logic      startPass;
    logic      passDone;
    layerCfg_t cfg;
    pixelSum_t pixelSum;

    ////////////////////////////////////////////////////////////
    // command decode and bank select
    convDecode uDecode (
        .clk       (clk),
        .convRst   (convRst),
        .cmd       (cmd),
        .passDone  (passDone),
        .startPass (startPass),
        .cfg       (cfg)
    );

    // window walk and MAC
    convExecute uExecute (
        .clk            (clk),
        .convRst        (convRst),
        .startPass      (startPass),
        .cfg            (cfg),
        .fmReadAddr     (fmReadAddr),
        .fmReadData     (fmReadData),
        .weightReadAddr (weightReadAddr),
        .weightReadData (weightReadData),
        .pixelSum       (pixelSum)
    );

    // bias, saturation and write back
    convResult uResult (
        .clk          (clk),
        .convRst      (convRst),
        .startPass    (startPass),
        .cfg          (cfg),
        .pixelSum     (pixelSum),
        .biasReadAddr (biasReadAddr),
        .biasReadData (biasReadData),
        .layerWr      (layerWr),
        .passDone     (passDone),
        .convStatus   (convStatus)
    );

endmodule

// File: hdl/convEnginePkg.sv
`include "convEngine_params.svh"

package convEnginePkg;

    // layer commands
    typedef enum logic [1:0] {
        OP_IDLE     = 2'd0,
        OP_CONV_A2B = 2'd1,     // bank A in, bank B out
        OP_CONV_B2A = 2'd2
    } layerOp_t;

    typedef struct packed {
        logic     valid;
        layerOp_t op;
    } layerCmd_t;

    // bank pair for one pass
    typedef struct packed {
        logic [`LAYER_ADDR_WIDTH-1:0] inBase;
        logic [`LAYER_ADDR_WIDTH-1:0] outBase;
    } layerCfg_t;

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_FETCH,
        WALK_DRAIN
    } walkState_t;

    // one finished output pixel, before bias
    typedef struct packed {
        logic                         valid;
        logic [`KIDX_WIDTH-1:0]       kernel;
        logic                         last;     // final pixel of the pass
        logic signed [`ACC_WIDTH-1:0] acc;
    } pixelSum_t;

    typedef struct packed {
        logic                         valid;
        logic [`LAYER_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]       data;
    } layerWrite_t;

endpackage

// File: hdl/convEngine_params.svh
`ifndef CONV_ENGINE_PARAMS_SVH
`define CONV_ENGINE_PARAMS_SVH

////////////////////////////////////////////////////////////
// data path widths
`define DATA_WIDTH          16
`define ACC_WIDTH           32
`define FRAC_BITS           8       // accumulator shift before bias add

////////////////////////////////////////////////////////////
// layer geometry
`define FM_SIZE             8
`define FM_DEPTH            2
`define KERNEL_SIZE         3
`define KERNEL_NUMBER       2
`define OUT_SIZE            (`FM_SIZE - `KERNEL_SIZE + 1)

// counter widths for the window walk
`define KIDX_WIDTH          1       // kernel index, also bias address
`define POS_WIDTH           3       // output x and y
`define DEPTH_WIDTH         1
`define KSIDE_WIDTH         2       // kernel row and column

////////////////////////////////////////////////////////////
// memory map
`define LAYER_ADDR_WIDTH    9
`define WEIGHT_ADDR_WIDTH   4
`define WEIGHT_ROW_WIDTH    (`KERNEL_SIZE * `DATA_WIDTH)
`define BANK_A_BASE         0
`define BANK_B_BASE         256

`endif

// File: hdl/convExecute.sv
`include "convEngine_params.svh"

module convExecute (
    input  logic                            clk,
    input  logic                            convRst,
    input  logic                            startPass,
    input  convEnginePkg::layerCfg_t        cfg,
    output logic [`LAYER_ADDR_WIDTH-1:0]    fmReadAddr,
    input  logic [`DATA_WIDTH-1:0]          fmReadData,
    output logic [`WEIGHT_ADDR_WIDTH-1:0]   weightReadAddr,
    input  logic [`WEIGHT_ROW_WIDTH-1:0]    weightReadData,
    output convEnginePkg::pixelSum_t        pixelSum
);
    import convEnginePkg::*;

    // travels down the pipe beside each fetched sample
    typedef struct packed {
        logic                    valid;
        logic [`KSIDE_WIDTH-1:0] col;
        logic                    first;     // opens a new pixel
        logic                    lastPix;
        logic                    lastPass;
        logic [`KIDX_WIDTH-1:0]  kernel;
    } fetchTag_t;

    walkState_t state;

    logic [`KIDX_WIDTH-1:0]  kCnt;
    logic [`POS_WIDTH-1:0]   yCnt;
    logic [`POS_WIDTH-1:0]   xCnt;
    logic [`DEPTH_WIDTH-1:0] dCnt;
    logic [`KSIDE_WIDTH-1:0] rCnt;
    logic [`KSIDE_WIDTH-1:0] cCnt;

    logic colEnd;
    logic rowEnd;
    logic depthEnd;
    logic xEnd;
    logic yEnd;
    logic kEnd;
    logic pixelEnd;
    logic passEnd;

    logic [`LAYER_ADDR_WIDTH-1:0]  fmRow;
    logic [`LAYER_ADDR_WIDTH-1:0]  fmCol;
    logic [`LAYER_ADDR_WIDTH-1:0]  fmAddrNext;
    logic [`WEIGHT_ADDR_WIDTH-1:0] weightAddrNext;

    fetchTag_t curTag;
    fetchTag_t issueTag;    // lines up with the addresses
    fetchTag_t dataTag;     // lines up with the returned data
    fetchTag_t prodTag;     // lines up with prodQ

    logic [`WEIGHT_ROW_WIDTH-1:0]  weightRowQ;
    logic [`WEIGHT_ROW_WIDTH-1:0]  weightWord;
    logic signed [`DATA_WIDTH-1:0] weightCol;
    logic signed [`ACC_WIDTH-1:0]  prodQ;
    logic signed [`ACC_WIDTH-1:0]  acc;
    logic signed [`ACC_WIDTH-1:0]  accNext;

    ////////////////////////////////////////////////////////////
    // loop ends, innermost first
    assign colEnd   = cCnt == `KSIDE_WIDTH'(`KERNEL_SIZE - 1);
    assign rowEnd   = rCnt == `KSIDE_WIDTH'(`KERNEL_SIZE - 1);
    assign depthEnd = dCnt == `DEPTH_WIDTH'(`FM_DEPTH - 1);
    assign xEnd     = xCnt == `POS_WIDTH'(`OUT_SIZE - 1);
    assign yEnd     = yCnt == `POS_WIDTH'(`OUT_SIZE - 1);
    assign kEnd     = kCnt == `KIDX_WIDTH'(`KERNEL_NUMBER - 1);
    assign pixelEnd = colEnd && rowEnd && depthEnd;
    assign passEnd  = pixelEnd && xEnd && yEnd && kEnd;

    // inBase + d*64 + (y+r)*8 + (x+c)
    assign fmRow = `LAYER_ADDR_WIDTH'(yCnt) + `LAYER_ADDR_WIDTH'(rCnt);
    assign fmCol = `LAYER_ADDR_WIDTH'(xCnt) + `LAYER_ADDR_WIDTH'(cCnt);
    assign fmAddrNext = cfg.inBase
        + `LAYER_ADDR_WIDTH'(dCnt) * `LAYER_ADDR_WIDTH'(`FM_SIZE * `FM_SIZE)
        + fmRow * `LAYER_ADDR_WIDTH'(`FM_SIZE)
        + fmCol;

    // k*6 + d*3 + r
    assign weightAddrNext =
          `WEIGHT_ADDR_WIDTH'(kCnt) * `WEIGHT_ADDR_WIDTH'(`FM_DEPTH * `KERNEL_SIZE)
        + `WEIGHT_ADDR_WIDTH'(dCnt) * `WEIGHT_ADDR_WIDTH'(`KERNEL_SIZE)
        + `WEIGHT_ADDR_WIDTH'(rCnt);

    always_comb begin
        curTag.valid    = (state == WALK_FETCH);
        curTag.col      = cCnt;
        curTag.first    = (dCnt == '0) && (rCnt == '0) && (cCnt == '0);
        curTag.lastPix  = pixelEnd;
        curTag.lastPass = passEnd;
        curTag.kernel   = kCnt;
    end

    ////////////////////////////////////////////////////////////
    // walk FSM, one sample fetched per cycle
    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            state <= WALK_IDLE;
            kCnt  <= '0;
            yCnt  <= '0;
            xCnt  <= '0;
            dCnt  <= '0;
            rCnt  <= '0;
            cCnt  <= '0;
        end else begin
            case (state)
                WALK_IDLE: begin
                    if (startPass) begin
                        kCnt  <= '0;
                        yCnt  <= '0;
                        xCnt  <= '0;
                        dCnt  <= '0;
                        rCnt  <= '0;
                        cCnt  <= '0;
                        state <= WALK_FETCH;
                    end
                end
                WALK_FETCH: begin
                    cCnt <= colEnd ? '0 : cCnt + 1'b1;
                    if (colEnd) begin
                        rCnt <= rowEnd ? '0 : rCnt + 1'b1;
                        if (rowEnd) begin
                            dCnt <= depthEnd ? '0 : dCnt + 1'b1;
                            if (depthEnd) begin     // pixel done, next x
                                xCnt <= xEnd ? '0 : xCnt + 1'b1;
                                if (xEnd) begin
                                    yCnt <= yEnd ? '0 : yCnt + 1'b1;
                                    if (yEnd) begin
                                        kCnt <= kEnd ? '0 : kCnt + 1'b1;
                                    end
                                end
                            end
                        end
                    end
                    if (passEnd) begin
                        state <= WALK_DRAIN;
                    end
                end
                WALK_DRAIN: begin
                    // wait for the last sum to leave the pipe
                    if (prodTag.valid && prodTag.lastPass) begin
                        state <= WALK_IDLE;
                    end
                end
                default: state <= WALK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WALK_FETCH) begin
            fmReadAddr <= fmAddrNext;
            if (cCnt == '0) begin   // one weight row per kernel row
                weightReadAddr <= weightAddrNext;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // multiply and accumulate
    assign weightWord = (dataTag.col == '0) ? weightReadData : weightRowQ;
    assign weightCol  = $signed(weightWord[dataTag.col * `DATA_WIDTH +: `DATA_WIDTH]);
    assign accNext    = prodTag.first ? prodQ : acc + prodQ;

    always_ff @(posedge clk) begin
        if (dataTag.valid && dataTag.col == '0) begin
            weightRowQ <= weightReadData;   // reused by columns 1 and 2
        end
        prodQ <= $signed(fmReadData) * weightCol;
        if (prodTag.valid) begin
            acc <= accNext;
        end
    end

    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            issueTag <= '0;
            dataTag  <= '0;
            prodTag  <= '0;
            pixelSum <= '0;
        end else begin
            issueTag       <= curTag;
            dataTag        <= issueTag;
            prodTag        <= dataTag;
            pixelSum.valid <= prodTag.valid && prodTag.lastPix;
            if (prodTag.valid && prodTag.lastPix) begin
                pixelSum.kernel <= prodTag.kernel;
                pixelSum.last   <= prodTag.lastPass;
                pixelSum.acc    <= accNext;
            end
        end
    end

endmodule

// File: hdl/convResult.sv
`include "convEngine_params.svh"

module convResult (
    input  logic                         clk,
    input  logic                         convRst,
    input  logic                         startPass,
    input  convEnginePkg::layerCfg_t     cfg,
    input  convEnginePkg::pixelSum_t     pixelSum,
    output logic [`KIDX_WIDTH-1:0]       biasReadAddr,
    input  logic [`DATA_WIDTH-1:0]       biasReadData,
    output convEnginePkg::layerWrite_t   layerWr,
    output logic                         passDone,
    output logic                         convStatus
);
    import convEnginePkg::*;

    // signed 16 bit limits, one bit wider than the accumulator
    localparam logic signed [`ACC_WIDTH:0] SAT_MAX = 2 ** (`DATA_WIDTH - 1) - 1;
    localparam logic signed [`ACC_WIDTH:0] SAT_MIN = -(2 ** (`DATA_WIDTH - 1));

    pixelSum_t sumQ;    // waits one cycle for the bias

    logic [`LAYER_ADDR_WIDTH-1:0] wrCnt;
    logic signed [`ACC_WIDTH-1:0] scaled;
    logic signed [`ACC_WIDTH:0]   biased;
    logic [`DATA_WIDTH-1:0]       satWord;

    assign biasReadAddr = pixelSum.kernel;  // bias lands with sumQ

    ////////////////////////////////////////////////////////////
    // scale, bias, saturate
    assign scaled = $signed(sumQ.acc) >>> `FRAC_BITS;
    assign biased = scaled + $signed(biasReadData);

    always_comb begin
        if (biased > SAT_MAX) begin
            satWord = SAT_MAX[`DATA_WIDTH-1:0];
        end else if (biased < SAT_MIN) begin
            satWord = SAT_MIN[`DATA_WIDTH-1:0];
        end else begin
            satWord = biased[`DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            sumQ       <= '0;
            layerWr    <= '0;
            wrCnt      <= '0;
            passDone   <= 1'b0;
            convStatus <= 1'b0;
        end else begin
            sumQ          <= pixelSum;
            layerWr.valid <= sumQ.valid;
            passDone      <= sumQ.valid && sumQ.last;
            if (sumQ.valid) begin
                layerWr.addr <= cfg.outBase + wrCnt;    // pixel order k, y, x
                layerWr.data <= satWord;
            end

            if (startPass) begin
                wrCnt <= '0;
            end else if (sumQ.valid) begin
                wrCnt <= wrCnt + 1'b1;
            end

            // done flag, up the cycle after the last write
            if (startPass) begin
                convStatus <= 1'b0;
            end else if (passDone) begin
                convStatus <= 1'b1;
            end
        end
    end

endmodule

// File: verification/convChecker.sv
`include "convEngine_params.svh"

module convChecker (
    input  logic                         clk,
    input  logic                         convRst,
    input  convEnginePkg::layerCmd_t     cmd,
    input  convEnginePkg::layerWrite_t   layerWr,
    input  logic                         convStatus,
    input  logic [`DATA_WIDTH-1:0]       layerRam [1 << `LAYER_ADDR_WIDTH],
    input  logic [`WEIGHT_ROW_WIDTH-1:0] weightRam [1 << `WEIGHT_ADDR_WIDTH],
    input  logic [`DATA_WIDTH-1:0]       biasRam [`KERNEL_NUMBER],
    output int                           errors,
    output int                           writes
);
    import convEnginePkg::*;

    layerWrite_t expQ [$];      // expected writes of the running pass
    layerWrite_t want;
    logic        busy;
    logic        statusQ;
    logic        wrQ;           // write seen on the previous edge
    int          errCount = 0;
    int          wrCount  = 0;

    assign errors = errCount;
    assign writes = wrCount;

    ////////////////////////////////////////////////////////////
    // reference convolution, fixed point
    function automatic logic [`DATA_WIDTH-1:0] expectedPixel(int inBase, int k, int y, int x);
        int acc;
        int w;
        int sum;
        acc = 0;
        for (int d = 0; d < `FM_DEPTH; d++) begin
            for (int r = 0; r < `KERNEL_SIZE; r++) begin
                for (int c = 0; c < `KERNEL_SIZE; c++) begin
                    w = $signed(weightRam[k * `FM_DEPTH * `KERNEL_SIZE + d * `KERNEL_SIZE + r]
                        [c * `DATA_WIDTH +: `DATA_WIDTH]);
                    acc += $signed(layerRam[inBase + d * `FM_SIZE * `FM_SIZE
                        + (y + r) * `FM_SIZE + x + c]) * w;    // wraps like the 32 bit acc
                end
            end
        end
        sum = (acc >>> `FRAC_BITS) + int'($signed(biasRam[k]));
        if (sum > 32767) return 16'h7fff;
        if (sum < -32768) return 16'h8000;
        return sum[`DATA_WIDTH-1:0];
    endfunction

    // whole pass in k, y, x order
    task automatic queuePass(int inBase, int outBase);
        layerWrite_t w;
        for (int k = 0; k < `KERNEL_NUMBER; k++) begin
            for (int y = 0; y < `OUT_SIZE; y++) begin
                for (int x = 0; x < `OUT_SIZE; x++) begin
                    w.valid = 1'b1;
                    w.addr  = `LAYER_ADDR_WIDTH'(outBase + k * `OUT_SIZE * `OUT_SIZE
                        + y * `OUT_SIZE + x);
                    w.data  = expectedPixel(inBase, k, y, x);
                    expQ.push_back(w);
                end
            end
        end
    endtask

    always @(posedge clk or posedge convRst) begin
        if (convRst) begin
            busy    <= 1'b0;
            statusQ <= 1'b0;
            wrQ     <= 1'b0;
            expQ.delete();
        end else begin
            statusQ <= convStatus;
            wrQ     <= layerWr.valid;
            // a strobe during a pass is dropped by the DUT
            if (cmd.valid && !busy && cmd.op == OP_CONV_A2B) begin
                busy <= 1'b1;
                queuePass(`BANK_A_BASE, `BANK_B_BASE);
            end else if (cmd.valid && !busy && cmd.op == OP_CONV_B2A) begin
                busy <= 1'b1;
                queuePass(`BANK_B_BASE, `BANK_A_BASE);
            end

            if (layerWr.valid && expQ.size() == 0) begin
                errCount++;
                $display("layer write to address %0d at time %0t with no pass expected",
                    layerWr.addr, $time);
            end else if (layerWr.valid) begin
                want = expQ.pop_front();
                wrCount++;
                if (layerWr.addr != want.addr || layerWr.data != want.data) begin
                    errCount++;
                    $display("** Error @ %0t: write %0d:%h, expected %0d:%h", $time,
                        layerWr.addr, layerWr.data, want.addr, want.data);
                end
                if (expQ.size() == 0) busy <= 1'b0;
            end

            // status must come right behind the final write
            if (convStatus && !statusQ && (expQ.size() != 0 || !wrQ)) begin
                errCount++;
                $display("convStatus rose at time %0t with %0d writes still missing",
                    $time, expQ.size());
            end
        end
    end

endmodule

// File: verification/convEngineTb.sv
`include "convEngine_params.svh"

module convEngineTb;
    import convEnginePkg::*;

    localparam int PASS_WRITES = `KERNEL_NUMBER * `OUT_SIZE * `OUT_SIZE;
    localparam int NUM_CMDS    = 5;     // ignored strobe counted too
    localparam int CYCLE_LIMIT = 4 * NUM_CMDS * PASS_WRITES * 25;
    localparam int LAYER_WORDS = 1 << `LAYER_ADDR_WIDTH;
    localparam int WEIGHT_ROWS = 1 << `WEIGHT_ADDR_WIDTH;

    logic                          clk;
    logic                          convRst;
    layerCmd_t                     cmd;
    logic [`LAYER_ADDR_WIDTH-1:0]  fmReadAddr;
    logic [`DATA_WIDTH-1:0]        fmReadData = '0;
    logic [`WEIGHT_ADDR_WIDTH-1:0] weightReadAddr;
    logic [`WEIGHT_ROW_WIDTH-1:0]  weightReadData = '0;
    logic [`KIDX_WIDTH-1:0]        biasReadAddr;
    logic [`DATA_WIDTH-1:0]        biasReadData = '0;
    layerWrite_t                   layerWr;
    logic                          convStatus;

    logic [`DATA_WIDTH-1:0]       layerRam  [LAYER_WORDS];
    logic [`WEIGHT_ROW_WIDTH-1:0] weightRam [WEIGHT_ROWS];
    logic [`DATA_WIDTH-1:0]       biasRam   [`KERNEL_NUMBER];

    logic [31:0] lcgState    = 32'hc289;
    int          cycles      = 0;
    int          tbErrors    = 0;
    int          errMark     = 0;
    int          testsRun    = 0;
    int          testsFailed = 0;
    int          writeMark   = 0;
    int          chkErrors;
    int          chkWrites;

    convEngine DUT (.*);

    convChecker uChecker (
        .clk        (clk),
        .convRst    (convRst),
        .cmd        (cmd),
        .layerWr    (layerWr),
        .convStatus (convStatus),
        .layerRam   (layerRam),
        .weightRam  (weightRam),
        .biasRam    (biasRam),
        .errors     (chkErrors),
        .writes     (chkWrites)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // RAM models, one cycle read latency
    always @(posedge clk) begin
        fmReadData     <= layerRam[fmReadAddr];
        weightReadData <= weightRam[weightReadAddr];
        biasReadData   <= biasRam[biasReadAddr];
        if (layerWr.valid) layerRam[layerWr.addr] <= layerWr.data;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no pass finished within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // small signed samples, weights and biases
    task automatic fillSmall();
        logic [31:0]                  r;
        logic [`WEIGHT_ROW_WIDTH-1:0] row;
        for (int i = 0; i < LAYER_WORDS; i++) begin
            r = nextRand();
            layerRam[i] <= 16'($signed(r[23:16]));
        end
        for (int i = 0; i < WEIGHT_ROWS; i++) begin
            for (int c = 0; c < `KERNEL_SIZE; c++) begin
                r = nextRand();
                row[c * `DATA_WIDTH +: `DATA_WIDTH] = 16'($signed(r[22:16]));
            end
            weightRam[i] <= row;
        end
        for (int k = 0; k < `KERNEL_NUMBER; k++) begin
            r = nextRand();
            biasRam[k] <= 16'($signed(r[22:15]));
        end
    endtask

    // kernel 0 drives toward +max, kernel 1 toward -max
    task automatic fillLarge();
        logic [31:0]                  r;
        logic [`WEIGHT_ROW_WIDTH-1:0] row;
        for (int i = 0; i < `BANK_B_BASE; i++) begin
            r = nextRand();
            layerRam[i] <= {8'h01, r[23:16]};
        end
        for (int i = 0; i < WEIGHT_ROWS; i++) begin
            for (int c = 0; c < `KERNEL_SIZE; c++) begin
                r = nextRand();
                row[c * `DATA_WIDTH +: `DATA_WIDTH] = (i < `FM_DEPTH * `KERNEL_SIZE)
                    ? {2'b01, r[29:16]} : 16'h0 - {2'b01, r[29:16]};
            end
            weightRam[i] <= row;
        end
        biasRam[0] <= 16'h4000;
        biasRam[1] <= 16'hc000;
    endtask

    task automatic expectValue(string what, int got, int want);
        if (got != want) begin
            tbErrors++;
            $display("** Error @ %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // one cycle strobe, returns once convStatus has been cleared
    task automatic sendCmd(layerOp_t op);
        @(negedge clk);
        cmd.valid = 1'b1;
        cmd.op    = op;
        @(negedge clk);
        cmd = '0;
        @(negedge clk);
    endtask

    task automatic awaitPass();
        while (!convStatus) @(negedge clk);
        expectValue("write count of pass", chkWrites - writeMark, PASS_WRITES);
    endtask

    task automatic finishTest(string name);
        testsRun++;
        if (tbErrors + chkErrors != errMark) begin
            testsFailed++;
            $display("test %0d %s: FAILED", testsRun, name);
        end else begin
            $display("test %0d %s: ok", testsRun, name);
        end
        errMark = tbErrors + chkErrors;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        cmd     = '0;
        convRst = 1'b1;
        fillSmall();
        repeat (16) @(negedge clk);
        convRst = 1'b0;

        repeat (20) begin
            @(negedge clk);
            expectValue("layerWr.valid when idle", layerWr.valid, 0);
            expectValue("convStatus when idle", convStatus, 0);
        end
        finishTest("idle after reset");

        writeMark = chkWrites;
        sendCmd(OP_CONV_A2B);
        awaitPass();
        finishTest("conv A to B");

        repeat (20) begin
            @(negedge clk);
            expectValue("convStatus after pass", convStatus, 1);
        end
        writeMark = chkWrites;
        sendCmd(OP_CONV_B2A);
        expectValue("convStatus after new command", convStatus, 0);
        finishTest("status hold and clear");

        awaitPass();    // B2A pass started above
        finishTest("conv B to A");

        writeMark = chkWrites;
        sendCmd(OP_CONV_A2B);
        repeat (100) @(negedge clk);
        sendCmd(OP_CONV_B2A);   // mid pass, must be dropped
        awaitPass();
        // long enough for a wrongly queued pass to reach its first write
        repeat (50) begin
            @(negedge clk);
            expectValue("convStatus after dropped command", convStatus, 1);
        end
        expectValue("writes after dropped command", chkWrites - writeMark, PASS_WRITES);
        finishTest("command during pass");

        fillLarge();
        @(negedge clk);
        writeMark = chkWrites;
        sendCmd(OP_CONV_A2B);
        awaitPass();
        for (int i = 0; i < PASS_WRITES; i++) begin
            expectValue("saturated output", layerRam[`BANK_B_BASE + i],
                (i < PASS_WRITES / 2) ? 32'h7fff : 32'h8000);
        end
        finishTest("saturation");

        $display("%0d tests, %0d failed, %0d writes checked, %0d errors",
            testsRun, testsFailed, chkWrites, tbErrors + chkErrors);
        if (testsFailed == 0 && tbErrors + chkErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
